//--- ex_alu.sv
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_alu
    import ex_pkg::*;
(
    input  alu_op_e             alu_op_i,
    input  logic [`EX_XLEN-1:0] src1_i,
    input  logic [`EX_XLEN-1:0] src2_i,
    output logic [`EX_XLEN-1:0] result_o
);

    localparam int SHAMT_W = $clog2(`EX_XLEN);
    localparam int HALF_W  = `EX_XLEN / 2;

    logic [SHAMT_W-1:0]  shamt;
    logic [`EX_XLEN-1:0] sum;
    logic [`EX_XLEN-1:0] diff;
    logic                lt_signed;
    logic                lt_unsigned;

    // shift count from the low bits of src1, value comes from src2
    assign shamt = src1_i[SHAMT_W-1:0];

    // both wrap, no overflow trap here
    assign sum  = src1_i + src2_i;
    assign diff = src1_i - src2_i;

    assign lt_signed   = $signed(src1_i) < $signed(src2_i);
    assign lt_unsigned = src1_i < src2_i;

    always_comb begin
        case (alu_op_i)
            alu_add:  result_o = sum;
            alu_sub:  result_o = diff;
            alu_slt:  result_o = {{(`EX_XLEN-1){1'b0}}, lt_signed};
            alu_sltu: result_o = {{(`EX_XLEN-1){1'b0}}, lt_unsigned};
            alu_and:  result_o = src1_i & src2_i;
            alu_or:   result_o = src1_i | src2_i;
            alu_xor:  result_o = src1_i ^ src2_i;
            alu_nor:  result_o = ~(src1_i | src2_i);
            alu_sll:  result_o = src2_i << shamt;
            alu_srl:  result_o = src2_i >> shamt;
            // arithmetic shift keeps the sign
            alu_sra:  result_o = $unsigned($signed(src2_i) >>> shamt);
            // immediate into the upper half
            alu_lui:  result_o = {src2_i[HALF_W-1:0], {HALF_W{1'b0}}};
            default:  result_o = '0;
        endcase
    end

endmodule

//--- ex_branch_unit.sv
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_branch_unit
    import ex_pkg::*;
(
    input  br_op_e              br_op_i,
    input  logic [`EX_XLEN-1:0] pc_i,
    input  logic [`EX_XLEN-1:0] inst_i,
    input  logic [`EX_XLEN-1:0] rs_val_i,
    input  logic [`EX_XLEN-1:0] rt_val_i,
    output branch_t             branch_o
);

    logic [`EX_XLEN-1:0] pc_plus_4;
    logic [`EX_XLEN-1:0] cond_target;
    logic [`EX_XLEN-1:0] jump_target;
    logic                rs_eq_rt;
    logic                rs_neg;
    logic                rs_zero;
    logic                taken;
    logic [`EX_XLEN-1:0] target;

    // base is the delay slot address
    assign pc_plus_4   = pc_i + `EX_XLEN'(4);
    assign cond_target = pc_plus_4 + {{(`EX_XLEN-18){inst_i[15]}}, inst_i[15:0], 2'b00};
    // region jump keeps the top nibble
    assign jump_target = {pc_plus_4[`EX_XLEN-1:`EX_XLEN-4], inst_i[25:0], 2'b00};

    assign rs_eq_rt = rs_val_i == rt_val_i;
    assign rs_neg   = rs_val_i[`EX_XLEN-1];
    assign rs_zero  = rs_val_i == '0;

    always_comb begin
        case (br_op_i)
            br_beq:                       taken = rs_eq_rt;
            br_bne:                       taken = !rs_eq_rt;
            br_bgez, br_bgezal:           taken = !rs_neg;
            br_bgtz:                      taken = !rs_neg && !rs_zero;
            br_blez:                      taken = rs_neg || rs_zero;
            br_bltz, br_bltzal:           taken = rs_neg;
            br_j, br_jal, br_jr, br_jalr: taken = 1'b1;
            default:                      taken = 1'b0;
        endcase
    end

    always_comb begin
        case (br_op_i)
            br_beq, br_bne, br_bgez, br_bgtz,
            br_blez, br_bltz, br_bgezal, br_bltzal: target = cond_target;
            br_j, br_jal:                           target = jump_target;
            br_jr, br_jalr:                         target = rs_val_i;
            default:                                target = '0;
        endcase
    end

    assign branch_o = '{taken: taken, target: target};

    // redirect only from a real branch or jump
    always_comb begin
        a_taken_needs_op : assert (!branch_o.taken || br_op_i != br_none ||
                                   $isunknown(br_op_i))
            else $error("ex_branch_unit: taken without a branch op");
    end

endmodule

//--- ex_checker.sv
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_checker
    import ex_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  logic           flush_i,
    input  logic           stall_ex_i,
    input  logic           stall_mem_i,
    input  id_ex_bundle_t  id_ex_i,
    input  forward_t       fwd_i,
    input  ex_mem_bundle_t ex_mem_i,
    input  branch_t        branch_i,
    input  dmem_req_t      dmem_req_i,
    output int             err_count_o
);

    id_ex_bundle_t  mirror;
    logic           mirror_valid = 1'b0;
    int             errors = 0;
    ex_mem_bundle_t exp_em;
    branch_t        exp_br;
    dmem_req_t      exp_dm;

    // expected stage outputs for one registered instruction
    function automatic void predict(input id_ex_bundle_t b, input forward_t f,
                                    output ex_mem_bundle_t em, output branch_t br,
                                    output dmem_req_t dm);
        logic [`EX_XLEN-1:0] rs;
        logic [`EX_XLEN-1:0] rt;
        logic [`EX_XLEN-1:0] a;
        logic [`EX_XLEN-1:0] s;
        logic [`EX_XLEN-1:0] res;
        logic [`EX_XLEN-1:0] imm;
        logic [`EX_XLEN-1:0] pc4;
        rs = f.sel_rs ? f.rs_fwd : b.rs_data;
        rt = f.sel_rt ? f.rt_fwd : b.rt_data;
        imm = {{16{b.inst[15]}}, b.inst[15:0]};
        pc4 = b.pc + 32'd4;
        case (b.src1_sel)
            src1_pc: a = b.pc;
            src1_sa: a = {27'd0, b.inst[10:6]};
            default: a = rs;
        endcase
        case (b.src2_sel)
            src2_imm_sext: s = imm;
            src2_link8:    s = `EX_XLEN'(`EX_LINK_OFFSET);
            src2_imm_zext: s = {16'd0, b.inst[15:0]};
            default:       s = rt;
        endcase
        case (b.alu_op)
            alu_add:  res = a + s;
            alu_sub:  res = a - s;
            alu_slt:  res = ($signed(a) < $signed(s)) ? 32'd1 : 32'd0;
            alu_sltu: res = (a < s) ? 32'd1 : 32'd0;
            alu_and:  res = a & s;
            alu_or:   res = a | s;
            alu_xor:  res = a ^ s;
            alu_nor:  res = ~(a | s);
            alu_sll:  res = s << a[4:0];
            alu_srl:  res = s >> a[4:0];
            alu_sra:  res = $unsigned($signed(s) >>> a[4:0]);
            alu_lui:  res = {s[15:0], 16'd0};
            default:  res = '0;
        endcase
        em = '{mem_op: b.mem_op, pc: b.pc, mem_en: b.mem_en, sel_rf_res: b.sel_rf_res,
               rf_we: b.rf_we, rf_waddr: b.rf_waddr, ex_result: res};
        case (b.br_op)
            br_beq:              br = '{taken: rs == rt, target: pc4 + (imm << 2)};
            br_bne:              br = '{taken: rs != rt, target: pc4 + (imm << 2)};
            br_bgez, br_bgezal:  br = '{taken: $signed(rs) >= 0, target: pc4 + (imm << 2)};
            br_bgtz:             br = '{taken: $signed(rs) > 0, target: pc4 + (imm << 2)};
            br_blez:             br = '{taken: $signed(rs) <= 0, target: pc4 + (imm << 2)};
            br_bltz, br_bltzal:  br = '{taken: $signed(rs) < 0, target: pc4 + (imm << 2)};
            br_j, br_jal:        br = '{taken: 1'b1, target: {pc4[31:28], b.inst[25:0], 2'b00}};
            br_jr, br_jalr:      br = '{taken: 1'b1, target: rs};
            default:             br = '0;
        endcase
        dm = '{en: b.mem_en, wen: 4'b0000, addr: res, wdata: '0};
        if (b.store_op == st_sb) begin
            dm.wen = 4'b0001 << res[1:0];
            dm.wdata = {4{rt[7:0]}};
        end else if (b.store_op == st_sh) begin
            dm.wen = (res[1:0] == 2'd0) ? 4'b0011 : (res[1:0] == 2'd2) ? 4'b1100 : 4'b0000;
            dm.wdata = {2{rt[15:0]}};
        end else if (b.store_op == st_sw) begin
            dm.wen = 4'b1111;
            dm.wdata = rt;
        end
    endfunction

    // outputs of the previous edge are still settled here
    always @(posedge clk) begin
        if (mirror_valid) begin
            predict(mirror, fwd_i, exp_em, exp_br, exp_dm);
            if (ex_mem_i !== exp_em) begin
                $display("mismatch at %0t: ex_mem_o expected %h actual %h",
                         $time, exp_em, ex_mem_i);
                errors = errors + 1;
            end
            if (branch_i !== exp_br) begin
                $display("mismatch at %0t: branch_o expected %h actual %h",
                         $time, exp_br, branch_i);
                errors = errors + 1;
            end
            if (dmem_req_i !== exp_dm) begin
                $display("mismatch at %0t: dmem_req_o expected %h actual %h",
                         $time, exp_dm, dmem_req_i);
                errors = errors + 1;
            end
        end
        // stage register: clear, bubble, hold, load
        if (rst || flush_i) begin
            mirror <= '0;
        end else if (stall_ex_i && !stall_mem_i) begin
            mirror <= '0;
        end else if (!stall_ex_i) begin
            mirror <= id_ex_i;
        end
        if (rst) begin
            mirror_valid <= 1'b1;
        end
    end

    assign err_count_o = errors;

endmodule

//--- ex_defs.svh
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// datapath and address width
`define EX_XLEN 32

// register file address width
`define EX_RADDR_W 5

// load kind code handed on to the memory stage
`define EX_MEM_OP_W 5

// one strobe per byte lane
`define EX_WSTRB_W 4

// return address offset for link instructions (delay slot skipped)
`define EX_LINK_OFFSET 8

`endif

//--- ex_operand_sel.sv
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_operand_sel
    import ex_pkg::*;
(
    input  id_ex_bundle_t       bundle_i,
    input  forward_t            fwd_i,
    output logic [`EX_XLEN-1:0] rs_val_o,
    output logic [`EX_XLEN-1:0] rt_val_o,
    output logic [`EX_XLEN-1:0] src1_o,
    output logic [`EX_XLEN-1:0] src2_o
);

    logic [`EX_XLEN-1:0] imm_sext;
    logic [`EX_XLEN-1:0] imm_zext;
    logic [`EX_XLEN-1:0] sa_zext;

    // bypass wins over the register file read
    assign rs_val_o = fwd_i.sel_rs ? fwd_i.rs_fwd : bundle_i.rs_data;
    assign rt_val_o = fwd_i.sel_rt ? fwd_i.rt_fwd : bundle_i.rt_data;

    assign imm_sext = {{(`EX_XLEN-16){bundle_i.inst[15]}}, bundle_i.inst[15:0]};
    assign imm_zext = {{(`EX_XLEN-16){1'b0}}, bundle_i.inst[15:0]};
    // shamt field
    assign sa_zext  = {{(`EX_XLEN-5){1'b0}}, bundle_i.inst[10:6]};

    always_comb begin
        case (bundle_i.src1_sel)
            src1_pc: src1_o = bundle_i.pc;
            src1_sa: src1_o = sa_zext;
            default: src1_o = rs_val_o;
        endcase
    end

    always_comb begin
        case (bundle_i.src2_sel)
            src2_imm_sext: src2_o = imm_sext;
            src2_link8:    src2_o = `EX_XLEN'(`EX_LINK_OFFSET);
            src2_imm_zext: src2_o = imm_zext;
            default:       src2_o = rt_val_o;
        endcase
    end

endmodule

//--- ex_pkg.sv
`include "ex_defs.svh"

package ex_pkg;

    // alu operations, add at zero so a cleared bundle is harmless
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_e;

    // branch and jump kinds
    typedef enum logic [3:0] {
        br_none,
        br_beq,
        br_bne,
        br_bgez,
        br_bgtz,
        br_blez,
        br_bltz,
        br_bgezal,
        br_bltzal,
        br_j,
        br_jal,
        br_jr,
        br_jalr
    } br_op_e;

    typedef enum logic [1:0] {
        st_none,
        st_sb,
        st_sh,
        st_sw
    } store_op_e;

    // alu source 1 choice
    typedef enum logic [1:0] {
        src1_rs,
        src1_pc,
        src1_sa
    } src1_sel_e;

    // alu source 2 choice
    typedef enum logic [1:0] {
        src2_rt,
        src2_imm_sext,
        src2_link8,
        src2_imm_zext
    } src2_sel_e;

    // decoded instruction from the decode stage
    typedef struct packed {
        logic [`EX_XLEN-1:0]     pc;
        logic [`EX_XLEN-1:0]     inst;
        alu_op_e                 alu_op;
        br_op_e                  br_op;
        store_op_e               store_op;
        src1_sel_e               src1_sel;
        src2_sel_e               src2_sel;
        logic [`EX_MEM_OP_W-1:0] mem_op;
        logic                    mem_en;
        logic                    rf_we;
        logic [`EX_RADDR_W-1:0]  rf_waddr;
        logic                    sel_rf_res;
        logic [`EX_XLEN-1:0]     rs_data;
        logic [`EX_XLEN-1:0]     rt_data;
    } id_ex_bundle_t;

    // bypass values from mem and wb
    typedef struct packed {
        logic                sel_rs;
        logic [`EX_XLEN-1:0] rs_fwd;
        logic                sel_rt;
        logic [`EX_XLEN-1:0] rt_fwd;
    } forward_t;

    typedef struct packed {
        logic [`EX_MEM_OP_W-1:0] mem_op;
        logic [`EX_XLEN-1:0]     pc;
        logic                    mem_en;
        logic                    sel_rf_res;
        logic                    rf_we;
        logic [`EX_RADDR_W-1:0]  rf_waddr;
        logic [`EX_XLEN-1:0]     ex_result;
    } ex_mem_bundle_t;

    typedef struct packed {
        logic                taken;
        logic [`EX_XLEN-1:0] target;
    } branch_t;

    // data memory request
    typedef struct packed {
        logic                   en;
        logic [`EX_WSTRB_W-1:0] wen;
        logic [`EX_XLEN-1:0]    addr;
        logic [`EX_XLEN-1:0]    wdata;
    } dmem_req_t;

endpackage

//--- ex_stage.sv
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_stage
    import ex_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  logic           flush_i,
    input  logic           stall_ex_i,
    input  logic           stall_mem_i,
    input  id_ex_bundle_t  id_ex_i,
    input  forward_t       fwd_i,
    output ex_mem_bundle_t ex_mem_o,
    output branch_t        branch_o,
    output dmem_req_t      dmem_req_o
);

    id_ex_bundle_t       ex_bundle;
    logic [`EX_XLEN-1:0] rs_val;
    logic [`EX_XLEN-1:0] rt_val;
    logic [`EX_XLEN-1:0] src1;
    logic [`EX_XLEN-1:0] src2;
    logic [`EX_XLEN-1:0] alu_result;

    ex_stage_reg u_stage_reg (
        .clk         (clk),
        .rst         (rst),
        .flush_i     (flush_i),
        .stall_ex_i  (stall_ex_i),
        .stall_mem_i (stall_mem_i),
        .id_ex_i     (id_ex_i),
        .bundle_o    (ex_bundle)
    );

    ex_operand_sel u_operand_sel (
        .bundle_i (ex_bundle),
        .fwd_i    (fwd_i),
        .rs_val_o (rs_val),
        .rt_val_o (rt_val),
        .src1_o   (src1),
        .src2_o   (src2)
    );

    ex_alu u_alu (
        .alu_op_i (ex_bundle.alu_op),
        .src1_i   (src1),
        .src2_i   (src2),
        .result_o (alu_result)
    );

    ex_branch_unit u_branch_unit (
        .br_op_i  (ex_bundle.br_op),
        .pc_i     (ex_bundle.pc),
        .inst_i   (ex_bundle.inst),
        .rs_val_i (rs_val),
        .rt_val_i (rt_val),
        .branch_o (branch_o)
    );

    // store address is the alu sum of base and offset
    ex_store_format u_store_format (
        .store_op_i (ex_bundle.store_op),
        .mem_en_i   (ex_bundle.mem_en),
        .addr_i     (alu_result),
        .rt_val_i   (rt_val),
        .dmem_req_o (dmem_req_o)
    );

    assign ex_mem_o = '{
        mem_op:     ex_bundle.mem_op,
        pc:         ex_bundle.pc,
        mem_en:     ex_bundle.mem_en,
        sel_rf_res: ex_bundle.sel_rf_res,
        rf_we:      ex_bundle.rf_we,
        rf_waddr:   ex_bundle.rf_waddr,
        ex_result:  alu_result
    };

endmodule

//--- ex_stage_reg.sv
`timescale 1ns/100ps

module ex_stage_reg
    import ex_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          flush_i,
    input  logic          stall_ex_i,
    input  logic          stall_mem_i,
    input  id_ex_bundle_t id_ex_i,
    output id_ex_bundle_t bundle_o
);

    logic bubble;
    logic hold;

    // ex stalled but mem free, so send a nop down the pipe
    assign bubble = stall_ex_i && !stall_mem_i;
    // both stalled, keep the current instruction
    assign hold = stall_ex_i && stall_mem_i;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            bundle_o <= '0;
        end else if (bubble) begin
            bundle_o <= '0;
        end else if (!hold) begin
            bundle_o <= id_ex_i;
        end
    end

    // a killed slot must not write anything downstream
    a_clear_kills_side_effects : assert property (
        @(posedge clk) (rst || flush_i) |=> (!bundle_o.rf_we && !bundle_o.mem_en)
    ) else $error("ex_stage_reg: side effects live after reset or flush");

endmodule

//--- ex_store_format.sv
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_store_format
    import ex_pkg::*;
(
    input  store_op_e           store_op_i,
    input  logic                mem_en_i,
    input  logic [`EX_XLEN-1:0] addr_i,
    input  logic [`EX_XLEN-1:0] rt_val_i,
    output dmem_req_t           dmem_req_o
);

    logic [`EX_WSTRB_W-1:0] wen;
    logic [`EX_XLEN-1:0]    wdata;
    logic [1:0]             offset;

    // byte offset inside the word
    assign offset = addr_i[1:0];

    always_comb begin
        case (store_op_i)
            st_sb: begin
                // same byte on every lane, strobe picks one
                wdata = {4{rt_val_i[7:0]}};
                wen   = `EX_WSTRB_W'(1) << offset;
            end
            st_sh: begin
                wdata = {2{rt_val_i[15:0]}};
                case (offset)
                    2'b00:   wen = 4'b0011;
                    2'b10:   wen = 4'b1100;
                    // odd halfword address, drop the write
                    default: wen = 4'b0000;
                endcase
            end
            st_sw: begin
                wdata = rt_val_i;
                wen   = 4'b1111;
            end
            default: begin
                wdata = '0;
                wen   = '0;
            end
        endcase
    end

    assign dmem_req_o = '{en: mem_en_i, wen: wen, addr: addr_i, wdata: wdata};

    // strobes are a single byte, an aligned half, the full word or nothing
    always_comb begin
        a_wen_legal : assert ($isunknown(dmem_req_o.wen) ||
                              dmem_req_o.wen inside {4'b0000, 4'b0001, 4'b0010, 4'b0100,
                                                     4'b1000, 4'b0011, 4'b1100, 4'b1111})
            else $error("ex_store_format: illegal strobe pattern %b", dmem_req_o.wen);
    end

endmodule

//--- filelist.f
+incdir+.
ex_pkg.sv
ex_stage_reg.sv
ex_operand_sel.sv
ex_alu.sv
ex_branch_unit.sv
ex_store_format.sv
ex_stage.sv
ex_checker.sv
tb_ex_stage.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_ex_stage -f filelist.f -o sim_ex_stage
./obj_dir/sim_ex_stage > sim.log
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi

//--- tb_ex_stage.sv
`timescale 1ns/100ps
`include "ex_defs.svh"

module tb_ex_stage
    import ex_pkg::*;
();

    localparam int TEST_CYCLES = 200;
    localparam int NUM_TESTS   = 5;
    localparam int MAX_CYCLES  = NUM_TESTS * TEST_CYCLES + 200;

    logic           clk = 1'b0;
    logic           rst;
    logic           flush;
    logic           stall_ex;
    logic           stall_mem;
    id_ex_bundle_t  id_ex;
    forward_t       fwd;
    ex_mem_bundle_t ex_mem;
    branch_t        branch;
    dmem_req_t      dmem_req;
    int             checker_errors;
    int             local_errors = 0;
    int             pass_cnt = 0;
    int             fail_cnt = 0;
    int             cycles = 0;
    logic [31:0]    lfsr = 32'h7890;

    always #20 clk = ~clk;

    ex_stage i_dut (
        .clk(clk), .rst(rst), .flush_i(flush), .stall_ex_i(stall_ex),
        .stall_mem_i(stall_mem), .id_ex_i(id_ex), .fwd_i(fwd),
        .ex_mem_o(ex_mem), .branch_o(branch), .dmem_req_o(dmem_req)
    );

    ex_checker i_checker (
        .clk(clk), .rst(rst), .flush_i(flush), .stall_ex_i(stall_ex),
        .stall_mem_i(stall_mem), .id_ex_i(id_ex), .fwd_i(fwd),
        .ex_mem_i(ex_mem), .branch_i(branch), .dmem_req_i(dmem_req),
        .err_count_o(checker_errors)
    );

    // galois form, taps 32,22,2,1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic make_stimulus(input int mode);
        logic [31:0]   r;
        id_ex_bundle_t b;
        forward_t      f;
        b.pc = rand_bits(32);
        b.inst = rand_bits(32);
        r = rand_bits(4);
        b.alu_op = alu_op_e'(r[3:0] % 4'd12);
        r = rand_bits(4);
        b.br_op = br_op_e'(r[3:0] % 4'd13);
        r = rand_bits(2);
        b.store_op = store_op_e'(r[1:0]);
        r = rand_bits(2);
        b.src1_sel = src1_sel_e'(r[1:0] % 2'd3);
        r = rand_bits(2);
        b.src2_sel = src2_sel_e'(r[1:0]);
        r = rand_bits(5);
        b.mem_op = r[4:0];
        r = rand_bits(8);
        b.mem_en = r[0];
        b.rf_we = r[1];
        b.sel_rf_res = r[2];
        b.rf_waddr = r[7:3];
        b.rs_data = rand_bits(32);
        b.rt_data = rand_bits(32);
        f = '0;
        case (mode)
            0: begin
                b.br_op = br_none;
                b.store_op = st_none;
            end
            1: begin
                r = rand_bits(2);
                f.sel_rs = r[0];
                f.sel_rt = r[1];
                f.rs_fwd = rand_bits(32);
                f.rt_fwd = rand_bits(32);
            end
            2: begin
                // make equal and zero operands common
                r = rand_bits(2);
                if (r[0]) b.rt_data = b.rs_data;
                if (r[1]) b.rs_data = '0;
            end
            3: begin
                b.alu_op = alu_add;
                b.src1_sel = src1_rs;
                b.src2_sel = src2_imm_sext;
                b.mem_en = 1'b1;
                r = rand_bits(2);
                b.store_op = (r[1:0] == 2'd0) ? st_sw : store_op_e'(r[1:0]);
            end
            default: begin
                r = rand_bits(5);
                flush = r[2:0] == 3'd0;
                stall_ex = r[3];
                stall_mem = r[4];
            end
        endcase
        id_ex = b;
        fwd = f;
    endtask

    task automatic check_idle(input string when);
        if (ex_mem.rf_we || ex_mem.mem_en || branch.taken || dmem_req.en ||
            dmem_req.wen != 4'b0000) begin
            $display("control outputs are active after %s at %0t", when, $time);
            local_errors = local_errors + 1;
        end
    endtask

    task automatic run_test(input string name, input int mode);
        int start;
        start = checker_errors + local_errors;
        if (mode == 4) begin
            @(posedge clk);
            #2 rst = 1'b1;
            @(posedge clk);
            #2 rst = 1'b0;
            check_idle("reset");
        end
        repeat (TEST_CYCLES) begin
            @(posedge clk);
            #2;
            make_stimulus(mode);
        end
        flush = 1'b0;
        stall_ex = 1'b0;
        stall_mem = 1'b0;
        // let the last instruction reach the compare
        repeat (2) @(posedge clk);
        #2;
        if (checker_errors + local_errors == start) begin
            $display("test %s: ok", name);
            pass_cnt = pass_cnt + 1;
        end else begin
            $display("test %s: %0d errors", name, checker_errors + local_errors - start);
            fail_cnt = fail_cnt + 1;
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the tests did not finish", MAX_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        flush = 1'b0;
        stall_ex = 1'b0;
        stall_mem = 1'b0;
        id_ex = '0;
        fwd = '0;
        repeat (4) @(posedge clk);
        #2 rst = 1'b0;
        run_test("alu", 0);
        run_test("forwarding", 1);
        run_test("branch", 2);
        run_test("store", 3);
        run_test("pipeline control", 4);
        $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
